/* common/host_term_defines.svh */
`ifndef HOST_TERM_DEFINES_SVH
`define HOST_TERM_DEFINES_SVH

// register bus widths
`define DATA_W          32
`define REG_ADDR_W      32
`define TERM_ADDR_W     16

// terminal addresses seen by the host
`define TERM_DUMMY      16'h0001
`define TERM_DRAM       16'h0003
`define TERM_DRAM_CTRL  16'h0004

// odd register addresses return this, even ones its complement
`define DUMMY_PATTERN   32'hBBAA9988

// on-chip word store standing in for the DRAM
`define DRAM_WORDS      256
`define DRAM_ADDR_W     8

`endif

/* common/host_term_pkg.sv */
`default_nettype none

`include "host_term_defines.svh"

package host_term_pkg;

   typedef enum logic [1:0] {
      sel_dram,
      sel_dram_ctrl,
      sel_dummy,
      sel_none
   } term_sel_t;

   typedef enum logic {
      mem_write,
      mem_read
   } mem_instr_t;

   typedef enum logic [2:0] {
      st_idle,
      st_write_wait,    // inside a write transfer
      st_read_issue,
      st_read_wait,
      st_read_hold      // word held for the host
   } dram_state_t;

   // control terminal register indices
   localparam logic [`REG_ADDR_W-1:0] ctrl_scratch  = 'd0;
   localparam logic [`REG_ADDR_W-1:0] ctrl_wr_count = 'd1;
   localparam logic [`REG_ADDR_W-1:0] ctrl_rd_count = 'd2;

endpackage

`default_nettype wire

/* common/term_if.sv */
`default_nettype none

`include "host_term_defines.svh"

// one terminal's slice of the host register bus
interface term_if;
   logic                   read_mode;
   logic                   read;
   logic                   write_mode;
   logic                   write;
   logic [`REG_ADDR_W-1:0] reg_addr;
   logic [`DATA_W-1:0]     reg_datai;
   logic [`DATA_W-1:0]     reg_datao;
   logic                   read_rdy;
   logic                   write_rdy;

   modport router (
      output read_mode, read, write_mode, write, reg_addr, reg_datai,
      input  reg_datao, read_rdy, write_rdy
   );

   modport terminal (
      input  read_mode, read, write_mode, write, reg_addr, reg_datai,
      output reg_datao, read_rdy, write_rdy
   );

endinterface

`default_nettype wire

/* common/mem_port_if.sv */
`default_nettype none

`include "host_term_defines.svh"

// command, write and read channels of the memory port
interface mem_port_if;
   logic                         cmd_en;
   host_term_pkg::mem_instr_t    cmd_instr;
   logic [`DRAM_ADDR_W-1:0]      cmd_addr;
   logic                         cmd_full;
   logic [`DATA_W-1:0]           wr_data;
   logic                         rd_en;
   logic [`DATA_W-1:0]           rd_data;
   logic                         rd_empty;

   modport master (
      output cmd_en, cmd_instr, cmd_addr, wr_data, rd_en,
      input  cmd_full, rd_data, rd_empty
   );

   modport slave (
      input  cmd_en, cmd_instr, cmd_addr, wr_data, rd_en,
      output cmd_full, rd_data, rd_empty
   );

endinterface

`default_nettype wire

/* src/term_router.sv */
`default_nettype none

`include "host_term_defines.svh"

module term_router (
   input  wire [`TERM_ADDR_W-1:0] term_addr,
   input  wire [`REG_ADDR_W-1:0]  reg_addr,
   input  wire                    read_mode,
   input  wire                    read,
   input  wire                    write_mode,
   input  wire                    write,
   input  wire [`DATA_W-1:0]      reg_datai,
   output logic [`DATA_W-1:0]     reg_datao,
   output logic                   read_rdy,
   output logic                   write_rdy,
   term_if.router                 dram_bus,
   term_if.router                 ctrl_bus
);

   host_term_pkg::term_sel_t sel;
   logic dram_hit;
   logic ctrl_hit;

   always_comb begin
      case (term_addr)
         `TERM_DRAM:      sel = host_term_pkg::sel_dram;
         `TERM_DRAM_CTRL: sel = host_term_pkg::sel_dram_ctrl;
         `TERM_DUMMY:     sel = host_term_pkg::sel_dummy;
         default:         sel = host_term_pkg::sel_none;
      endcase
   end

   assign dram_hit = (sel == host_term_pkg::sel_dram);
   assign ctrl_hit = (sel == host_term_pkg::sel_dram_ctrl);

   // unselected terminal sees no mode and no strobe
   assign dram_bus.read_mode  = read_mode & dram_hit;
   assign dram_bus.read       = read & dram_hit;
   assign dram_bus.write_mode = write_mode & dram_hit;
   assign dram_bus.write      = write & dram_hit;
   assign dram_bus.reg_addr   = reg_addr;
   assign dram_bus.reg_datai  = reg_datai;

   assign ctrl_bus.read_mode  = read_mode & ctrl_hit;
   assign ctrl_bus.read       = read & ctrl_hit;
   assign ctrl_bus.write_mode = write_mode & ctrl_hit;
   assign ctrl_bus.write      = write & ctrl_hit;
   assign ctrl_bus.reg_addr   = reg_addr;
   assign ctrl_bus.reg_datai  = reg_datai;

   always_comb begin
      case (sel)
         host_term_pkg::sel_dram: begin
            reg_datao = dram_bus.reg_datao;
            read_rdy  = dram_bus.read_rdy;
            write_rdy = dram_bus.write_rdy;
         end
         host_term_pkg::sel_dram_ctrl: begin
            reg_datao = ctrl_bus.reg_datao;
            read_rdy  = ctrl_bus.read_rdy;
            write_rdy = ctrl_bus.write_rdy;
         end
         host_term_pkg::sel_dummy: begin
            reg_datao = reg_addr[0] ? `DUMMY_PATTERN : ~`DUMMY_PATTERN;
            read_rdy  = 1'b1;
            write_rdy = 1'b1;   // writes are dropped
         end
         default: begin      // unmapped address
            reg_datao = '0;
            read_rdy  = 1'b1;
            write_rdy = 1'b1;
         end
      endcase
   end

endmodule

`default_nettype wire

/* src/ctrl_term.sv */
`default_nettype none

`include "host_term_defines.svh"

module ctrl_term (
   input  wire      ifclk,
   input  wire      reset,
   input  wire      word_written,
   input  wire      word_read,
   term_if.terminal bus
);

   logic [`DATA_W-1:0] scratch;
   logic [`DATA_W-1:0] wr_count;
   logic [`DATA_W-1:0] rd_count;
   logic               scratch_we;

   assign scratch_we = bus.write_mode && bus.write &&
                       (bus.reg_addr == host_term_pkg::ctrl_scratch);

   always_ff @(posedge ifclk) begin
      if (reset) begin
         scratch  <= '0;
         wr_count <= '0;
         rd_count <= '0;
      end else begin
         if (scratch_we)
            scratch <= bus.reg_datai;
         if (word_written)
            wr_count <= wr_count + 1'b1;
         if (word_read)
            rd_count <= rd_count + 1'b1;
      end
   end

   // counters are read only, writes to them fall through
   always_comb begin
      case (bus.reg_addr)
         host_term_pkg::ctrl_scratch:  bus.reg_datao = scratch;
         host_term_pkg::ctrl_wr_count: bus.reg_datao = wr_count;
         host_term_pkg::ctrl_rd_count: bus.reg_datao = rd_count;
         default:                      bus.reg_datao = '0;
      endcase
   end

   assign bus.read_rdy  = 1'b1;
   assign bus.write_rdy = 1'b1;

endmodule

`default_nettype wire

/* dram/dram_term.sv */
`default_nettype none

`include "host_term_defines.svh"

module dram_term (
   input  wire        ifclk,
   input  wire        reset,
   term_if.terminal   bus,
   mem_port_if.master mem,
   output logic       word_written,
   output logic       word_read
);

   host_term_pkg::dram_state_t state;
   logic [`DRAM_ADDR_W-1:0]    addr;
   logic [`DRAM_ADDR_W-1:0]    cur_addr;
   logic [`DATA_W-1:0]         hold;
   logic                       rd_pending;   // read issued but not yet popped
   logic                       wr_accept;
   logic                       rd_accept;
   logic                       rd_issue;
   logic                       in_idle;

   assign in_idle  = (state == host_term_pkg::st_idle);
   assign cur_addr = in_idle ? bus.reg_addr[`DRAM_ADDR_W-1:0] : addr;   // reload at mode start

   assign bus.write_rdy = bus.write_mode && !mem.cmd_full &&
                          (in_idle || state == host_term_pkg::st_write_wait);
   assign bus.read_rdy  = (state == host_term_pkg::st_read_hold);
   assign bus.reg_datao = hold;

   assign wr_accept = bus.write && bus.write_rdy;
   assign rd_accept = bus.read && bus.read_rdy;
   assign rd_issue  = (state == host_term_pkg::st_read_issue) && bus.read_mode && !mem.cmd_full;

   assign word_written = wr_accept;
   assign word_read    = rd_accept;

   // idle also drains a word left behind by an aborted read
   assign mem.rd_en = rd_pending && !mem.rd_empty &&
                      (in_idle || state == host_term_pkg::st_read_wait);

   always_ff @(posedge ifclk) begin
      if (reset) begin
         state      <= host_term_pkg::st_idle;
         addr       <= '0;
         rd_pending <= 1'b0;
         mem.cmd_en <= 1'b0;
      end else begin
         if (!mem.cmd_full)
            mem.cmd_en <= 1'b0;                 // command was taken
         if (wr_accept || rd_issue)
            mem.cmd_en <= 1'b1;
         if (rd_issue)
            rd_pending <= 1'b1;
         else if (mem.rd_en)
            rd_pending <= 1'b0;
         if (wr_accept)
            addr <= cur_addr + 1'b1;

         case (state)
            host_term_pkg::st_idle: begin
               if (bus.write_mode) begin
                  state <= host_term_pkg::st_write_wait;
                  if (!wr_accept)
                     addr <= cur_addr;
               end else if (bus.read_mode && !rd_pending) begin
                  state <= host_term_pkg::st_read_issue;
                  addr  <= cur_addr;
               end
            end
            host_term_pkg::st_write_wait: begin
               if (!bus.write_mode)
                  state <= host_term_pkg::st_idle;
            end
            host_term_pkg::st_read_issue: begin
               if (!bus.read_mode)
                  state <= host_term_pkg::st_idle;
               else if (rd_issue)
                  state <= host_term_pkg::st_read_wait;
            end
            host_term_pkg::st_read_wait: begin
               if (!bus.read_mode)
                  state <= host_term_pkg::st_idle;
               else if (!mem.rd_empty)
                  state <= host_term_pkg::st_read_hold;
            end
            host_term_pkg::st_read_hold: begin
               if (!bus.read_mode) begin
                  state <= host_term_pkg::st_idle;
               end else if (rd_accept) begin
                  addr  <= addr + 1'b1;
                  state <= host_term_pkg::st_read_issue;
               end
            end
            default: state <= host_term_pkg::st_idle;
         endcase
      end
   end

   // command payload and read hold register
   always_ff @(posedge ifclk) begin
      if (wr_accept) begin
         mem.cmd_instr <= host_term_pkg::mem_write;
         mem.cmd_addr  <= cur_addr;
         mem.wr_data   <= bus.reg_datai;
      end else if (rd_issue) begin
         mem.cmd_instr <= host_term_pkg::mem_read;
         mem.cmd_addr  <= addr;
      end
      if (mem.rd_en && state == host_term_pkg::st_read_wait)
         hold <= mem.rd_data;
   end

endmodule

`default_nettype wire

/* dram/dram_store.sv */
`default_nettype none

`include "host_term_defines.svh"

module dram_store (
   input  wire       ifclk,
   input  wire       reset,
   mem_port_if.slave mem
);

   logic [`DATA_W-1:0] store [`DRAM_WORDS];
   logic [`DATA_W-1:0] s1_data;             // array read stage
   logic               s1_valid;
   logic [`DATA_W-1:0] q_data [2];          // read queue, head in slot 0
   logic [1:0]         q_count;
   logic [3:0]         lfsr;
   logic               stall;
   logic               push;
   logic               pop;
   logic               push_slot;
   logic               cmd_take;

   // pseudo random stall gives the read path a varying latency
   assign stall     = lfsr[0] & lfsr[1];
   assign push      = s1_valid && !stall;
   assign pop       = mem.rd_en && (q_count != 2'd0);
   assign push_slot = q_count[0] ^ pop;     // first free slot after this cycle's pop
   assign cmd_take  = mem.cmd_en && !mem.cmd_full;

   // full when one more read would overrun the queue, or stage 1 is stuck
   assign mem.cmd_full = ((q_count + {1'b0, s1_valid}) >= 2'd2) || (s1_valid && stall);

   assign mem.rd_data  = q_data[0];
   assign mem.rd_empty = (q_count == 2'd0);

   always_ff @(posedge ifclk) begin
      if (cmd_take && mem.cmd_instr == host_term_pkg::mem_write)
         store[mem.cmd_addr] <= mem.wr_data;
      if (cmd_take && mem.cmd_instr == host_term_pkg::mem_read)
         s1_data <= store[mem.cmd_addr];
   end

   always_ff @(posedge ifclk) begin
      if (pop)
         q_data[0] <= q_data[1];
      if (push)
         q_data[push_slot] <= s1_data;      // wins over the shift into slot 0
   end

   always_ff @(posedge ifclk) begin
      if (reset) begin
         s1_valid <= 1'b0;
         q_count  <= '0;
         lfsr     <= 4'b1001;
      end else begin
         lfsr <= {lfsr[2:0], lfsr[3] ^ lfsr[2]};
         if (cmd_take && mem.cmd_instr == host_term_pkg::mem_read)
            s1_valid <= 1'b1;
         else if (push)
            s1_valid <= 1'b0;
         q_count <= q_count + {1'b0, push} - {1'b0, pop};
      end
   end

endmodule

`default_nettype wire

/* src/host_term_top.sv */
`default_nettype none

`include "host_term_defines.svh"

module host_term_top (
   input  wire                    ifclk,
   input  wire                    reset,
   input  wire [`TERM_ADDR_W-1:0] term_addr,
   input  wire [`REG_ADDR_W-1:0]  reg_addr,
   input  wire                    read_mode,
   input  wire                    read,
   input  wire                    write_mode,
   input  wire                    write,
   input  wire [`DATA_W-1:0]      reg_datai,
   output wire [`DATA_W-1:0]      reg_datao,
   output wire                    read_rdy,
   output wire                    write_rdy
);

   wire word_written;
   wire word_read;

   term_if     dram_bus ();
   term_if     ctrl_bus ();
   mem_port_if mem ();

   term_router term_router_inst (
      .term_addr  (term_addr),
      .reg_addr   (reg_addr),
      .read_mode  (read_mode),
      .read       (read),
      .write_mode (write_mode),
      .write      (write),
      .reg_datai  (reg_datai),
      .reg_datao  (reg_datao),
      .read_rdy   (read_rdy),
      .write_rdy  (write_rdy),
      .dram_bus   (dram_bus),
      .ctrl_bus   (ctrl_bus)
   );

   ctrl_term ctrl_term_inst (
      .ifclk        (ifclk),
      .reset        (reset),
      .word_written (word_written),
      .word_read    (word_read),
      .bus          (ctrl_bus)
   );

   dram_term dram_term_inst (
      .ifclk        (ifclk),
      .reset        (reset),
      .bus          (dram_bus),
      .mem          (mem),
      .word_written (word_written),
      .word_read    (word_read)
   );

   // stands in for the memory controller
   dram_store dram_store_inst (
      .ifclk (ifclk),
      .reset (reset),
      .mem   (mem)
   );

endmodule

`default_nettype wire

/* sim/tb_clock_gen.sv */
`default_nettype none

// free running ifclk, reset held over the first four rising edges
module tb_clock_gen (
   output logic ifclk,
   output logic reset
);
   timeunit 1ns;
   timeprecision 1ps;

   initial begin
      ifclk = 1'b0;
      forever #50 ifclk = ~ifclk;   // 100 ns period
   end

   initial begin
      reset <= 1'b1;
      repeat (4) @(posedge ifclk);
      reset <= 1'b0;
   end

endmodule

`default_nettype wire

/* sim/host_term_tb.sv */
`default_nettype none

`include "host_term_defines.svh"

module host_term_tb;
   timeunit 1ns;
   timeprecision 1ps;

   typedef enum {op_read, op_write, op_probe} op_t;

   localparam logic [`TERM_ADDR_W-1:0] t_dram     = `TERM_DRAM;
   localparam logic [`TERM_ADDR_W-1:0] t_ctrl     = `TERM_DRAM_CTRL;
   localparam logic [`TERM_ADDR_W-1:0] t_dummy    = `TERM_DUMMY;
   localparam logic [`REG_ADDR_W-1:0]  r_scratch  = host_term_pkg::ctrl_scratch;
   localparam logic [`REG_ADDR_W-1:0]  r_wr_count = host_term_pkg::ctrl_wr_count;
   localparam logic [`REG_ADDR_W-1:0]  r_rd_count = host_term_pkg::ctrl_rd_count;
   localparam int                      ready_limit = 64;   // cycles a DRAM word may take

   logic                    ifclk;
   logic                    reset;
   logic [`TERM_ADDR_W-1:0] term_addr;
   logic [`REG_ADDR_W-1:0]  reg_addr;
   logic                    read_mode;
   logic                    read;
   logic                    write_mode;
   logic                    write;
   logic [`DATA_W-1:0]      reg_datai;
   wire  [`DATA_W-1:0]      reg_datao;
   wire                     read_rdy;
   wire                     write_rdy;

   string                   tbl_name  [$];
   op_t                     tbl_op    [$];
   logic [`TERM_ADDR_W-1:0] tbl_term  [$];
   logic [`REG_ADDR_W-1:0]  tbl_addr  [$];
   int                      tbl_words [$];
   logic [`DATA_W-1:0]      tbl_data  [$];

   logic [`DATA_W-1:0] dram_model [`DRAM_WORDS];   // what the store should hold
   logic [31:0]        lfsr;
   int                 written_words;
   int                 read_words;
   int                 watchdog_cycles;
   bit                 table_ready = 1'b0;

   tb_clock_gen tb_clock_gen_inst (.ifclk(ifclk), .reset(reset));

   host_term_top host_term_top_inst (.*);

   task automatic add_entry(input string name, input op_t op, input logic [`TERM_ADDR_W-1:0] term,
                            input logic [`REG_ADDR_W-1:0] addr, input int words,
                            input logic [`DATA_W-1:0] data);
      tbl_name.push_back(name);
      tbl_op.push_back(op);
      tbl_term.push_back(term);
      tbl_addr.push_back(addr);
      tbl_words.push_back(words);
      tbl_data.push_back(data);
   endtask

   task automatic load_table();
      // name, operation, terminal, register address, words, data
      // data is unused for DRAM rows and counter reads
      add_entry("reset_no_mode",    op_probe, t_dram,   32'h0,         1,  32'h0);
      add_entry("dummy_odd",        op_read,  t_dummy,  32'h5,         1,  `DUMMY_PATTERN);
      add_entry("dummy_even",       op_read,  t_dummy,  32'h6,         1,  ~`DUMMY_PATTERN);
      add_entry("dummy_odd_high",   op_read,  t_dummy,  32'h8000_0011, 1,  `DUMMY_PATTERN);
      add_entry("scratch_write",    op_write, t_ctrl,   r_scratch,     1,  32'h5A5A_C3C3);
      add_entry("scratch_read",     op_read,  t_ctrl,   r_scratch,     1,  32'h5A5A_C3C3);
      add_entry("count_write",      op_write, t_ctrl,   r_wr_count,    1,  32'hDEAD_BEEF);
      add_entry("count_unchanged",  op_read,  t_ctrl,   r_wr_count,    1,  32'h0);
      add_entry("dram_burst_write", op_write, t_dram,   32'h20,        16, 32'h0);
      add_entry("dram_burst_read",  op_read,  t_dram,   32'h20,        16, 32'h0);
      add_entry("wr_count",         op_read,  t_ctrl,   r_wr_count,    1,  32'h0);
      add_entry("rd_count",         op_read,  t_ctrl,   r_rd_count,    1,  32'h0);
      add_entry("dram_reread",      op_read,  t_dram,   32'h26,        6,  32'h0);
      add_entry("dram_wrap_write",  op_write, t_dram,   32'hFC,        8,  32'h0);
      add_entry("dram_wrap_read",   op_read,  t_dram,   32'hFC,        8,  32'h0);
      add_entry("rd_count_final",   op_read,  t_ctrl,   r_rd_count,    1,  32'h0);
      add_entry("unmapped_read",    op_read,  16'h0007, 32'h3,         1,  32'h0);
   endtask

   function automatic logic [31:0] galois_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // one LFSR step per data bit
   function automatic logic [`DATA_W-1:0] random_word();
      logic [`DATA_W-1:0] w;
      w = '0;
      for (int b = 0; b < `DATA_W; b++) begin
         w    = {w[`DATA_W-2:0], lfsr[0]};
         lfsr = galois_step(lfsr);
      end
      return w;
   endfunction

   function automatic logic [`DRAM_ADDR_W-1:0] word_addr(input int idx, input int i);
      logic [`REG_ADDR_W-1:0] base;
      base = tbl_addr[idx];
      return base[`DRAM_ADDR_W-1:0] + i[`DRAM_ADDR_W-1:0];   // wraps at the store end
   endfunction

   function automatic logic [`DATA_W-1:0] expected_word(input int idx, input int i);
      if (tbl_term[idx] == t_dram)
         return dram_model[word_addr(idx, i)];
      if (tbl_term[idx] == t_ctrl && tbl_addr[idx] == r_wr_count)
         return written_words;
      if (tbl_term[idx] == t_ctrl && tbl_addr[idx] == r_rd_count)
         return read_words;
      return tbl_data[idx];
   endfunction

   task automatic stop_run(input string msg);
      $display("%s", msg);
      $display("Finished with errors");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [`DATA_W-1:0] exp,
                              input logic [`DATA_W-1:0] got);
      assert (got === exp)
      else stop_run($sformatf("Fail %s: expected %h, actual %h", name, exp, got));
   endtask

   // non DRAM terminals must be ready at once
   task automatic wait_ready(input int idx, input bit for_write);
      int limit;
      int n;
      bit rdy;
      limit = (tbl_term[idx] == t_dram) ? ready_limit : 1;
      n     = 0;
      rdy   = 1'b0;
      while (!rdy) begin
         @(negedge ifclk);
         rdy = for_write ? write_rdy : read_rdy;
         n++;
         if (!rdy && n >= limit)
            stop_run($sformatf("%s: %s stayed low for %0d cycles", tbl_name[idx],
                               for_write ? "write_rdy" : "read_rdy", n));
      end
   endtask

   task automatic run_entry(input int idx);
      logic [`DATA_W-1:0] data;
      bit                 dram;
      dram = (tbl_term[idx] == t_dram);
      @(posedge ifclk);
      term_addr <= tbl_term[idx];
      reg_addr  <= tbl_addr[idx];
      case (tbl_op[idx])
         op_probe: begin
            read <= 1'b1;   // strobe with no mode held
            @(negedge ifclk);
            check_value({tbl_name[idx], " read_rdy"}, '0, {31'd0, read_rdy});
            check_value({tbl_name[idx], " write_rdy"}, '0, {31'd0, write_rdy});
            @(posedge ifclk);
            read <= 1'b0;
         end
         op_read: begin
            read_mode <= 1'b1;
            for (int i = 0; i < tbl_words[idx]; i++) begin
               wait_ready(idx, 1'b0);
               check_value(tbl_name[idx], expected_word(idx, i), reg_datao);
               @(posedge ifclk);
               read <= 1'b1;
               @(posedge ifclk);
               read <= 1'b0;
               if (dram)
                  read_words++;
            end
            read_mode <= 1'b0;   // drops with the last strobe, no read ahead left behind
         end
         op_write: begin
            write_mode <= 1'b1;
            for (int i = 0; i < tbl_words[idx]; i++) begin
               data = dram ? random_word() : tbl_data[idx];
               wait_ready(idx, 1'b1);
               @(posedge ifclk);
               write     <= 1'b1;
               reg_datai <= data;
               @(posedge ifclk);
               write <= 1'b0;
               if (dram) begin
                  dram_model[word_addr(idx, i)] = data;
                  written_words++;
               end
            end
            write_mode <= 1'b0;
         end
      endcase
      repeat (4) @(posedge ifclk);   // bus idle between tests
   endtask

   initial begin
      term_addr  <= '0;
      reg_addr   <= '0;
      read_mode  <= 1'b0;
      read       <= 1'b0;
      write_mode <= 1'b0;
      write      <= 1'b0;
      reg_datai  <= '0;
      lfsr          = 32'd88963;
      written_words = 0;
      read_words    = 0;
      load_table();
      watchdog_cycles = 100;
      foreach (tbl_words[k])
         watchdog_cycles += 20 * tbl_words[k] + 20;   // 20 cycles a word plus setup
      table_ready = 1'b1;
      @(negedge ifclk);
      while (reset)
         @(negedge ifclk);
      foreach (tbl_name[k])
         run_entry(k);
      $display("Finished with no errors");
      $finish;
   end

   initial begin
      wait (table_ready);
      repeat (watchdog_cycles) @(posedge ifclk);
      stop_run($sformatf("timeout: the tests did not finish within %0d clock cycles",
                         watchdog_cycles));
   end

endmodule

`default_nettype wire

/* host_term.f */
+incdir+common
common/host_term_pkg.sv
common/term_if.sv
common/mem_port_if.sv
src/term_router.sv
src/ctrl_term.sv
dram/dram_term.sv
dram/dram_store.sv
src/host_term_top.sv
sim/tb_clock_gen.sv
sim/host_term_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile with Verilator, run the testbench, then scan the log for the failure line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
   -f host_term.f --top-module host_term_tb -Mdir obj_dir -o host_term_sim \
   > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/host_term_sim > sim.log 2>&1
cat sim.log

grep -q "Finished with errors" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
